/* src/ahb_cfg_pkg.sv */
// shared widths, config register map, reset windows and bus types; imported by every bridge block
package ahb_cfg_pkg;

	localparam int DATA_W     = 32;   // address and data width
	localparam int NUM_SLAVES = 4;
	localparam int CFG_LAST   = 8;    // config space is 0..CFG_LAST
	localparam int CFG_AW     = $clog2(CFG_LAST + 1);

	// widest legal transfer is one full data bus word
	localparam logic [2:0] MAX_HSIZE = 3'($clog2(DATA_W / 8));

	// map: 2k+1 is base of slave k, 2k+2 its size
	localparam logic [NUM_SLAVES-1:0][DATA_W-1:0] RESET_BASE = {
		DATA_W'('h8c00_0000),
		DATA_W'('h8800_0000),
		DATA_W'('h8400_0000),
		DATA_W'('h8000_0000)
	};
	localparam logic [NUM_SLAVES-1:0][DATA_W-1:0] RESET_SIZE = {NUM_SLAVES{DATA_W'('h3ff)}};

	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_e;

	typedef enum logic [1:0] {
		OKAY  = 2'b00,
		ERROR = 2'b10
	} hresp_e;

	typedef enum logic [1:0] {
		RESP_OK,
		RESP_ERR_FIRST,
		RESP_ERR_LAST
	} resp_state_e;

	// one address phase
	typedef struct packed {
		htrans_e           trans;
		logic [2:0]        size;
		logic              write;
		logic [DATA_W-1:0] addr;
	} ahb_req_t;

	typedef struct packed {
		logic [DATA_W-1:0] base;
		logic [DATA_W-1:0] size;
	} slave_window_t;

	typedef slave_window_t [NUM_SLAVES-1:0] window_array_t;

	function automatic logic is_cfg_addr(input logic [DATA_W-1:0] addr);
		return addr <= CFG_LAST;
	endfunction

	function automatic logic is_active(input htrans_e trans);
		return trans inside {NONSEQ, SEQ};
	endfunction

endpackage

/* src/ahb_cfg_regs.sv */
`timescale 1ns/1ps
// slave window register file behind config addresses 0x1-0x8, written in the data phase
module ahb_cfg_regs
	import ahb_cfg_pkg::*;
(
	input  logic              Hclk,
	input  logic              Hresetn,
	input  ahb_req_t          req,
	input  logic              Hreadyin,
	input  logic [DATA_W-1:0] Hwdata,
	input  logic              error_flag,
	input  logic              resp_busy,
	output window_array_t     windows,
	output logic [DATA_W-1:0] config_reg_data,
	output logic              cfg_write_phase
);

	logic              accept;
	logic              cfg_hit;
	logic              wr_pending;   // config write waiting on its data phase
	logic [CFG_AW-1:0] wr_idx;
	logic              wr_en;
	logic [DATA_W-1:0] rd_word;

	assign accept          = Hreadyin && is_active(req.trans) && !resp_busy;
	assign cfg_hit         = is_cfg_addr(req.addr);
	assign cfg_write_phase = is_active(req.trans) && req.write && cfg_hit;

	// data phase ends on Hreadyin, an error in it kills the write
	assign wr_en = wr_pending && Hreadyin && !error_flag && !resp_busy;

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			wr_pending <= 1'b0;
		else if (Hreadyin || error_flag)
			wr_pending <= accept && cfg_hit && req.write;
	end

	always_ff @(posedge Hclk)
	begin
		if (accept)
			wr_idx <= req.addr[CFG_AW-1:0];
	end

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			for (int k = 0; k < NUM_SLAVES; k++)
			begin
				windows[k].base <= RESET_BASE[k];
				windows[k].size <= RESET_SIZE[k];
			end
		end
		else if (wr_en)
		begin
			for (int k = 0; k < NUM_SLAVES; k++)
			begin
				if (wr_idx == CFG_AW'(2 * k + 1))
					windows[k].base <= Hwdata;
				if (wr_idx == CFG_AW'(2 * k + 2))
					windows[k].size <= Hwdata;
			end
		end
	end

	always_comb
	begin
		rd_word = '0;   // 0x0 reads zero
		for (int k = 0; k < NUM_SLAVES; k++)
		begin
			if (req.addr[CFG_AW-1:0] == CFG_AW'(2 * k + 1))
				rd_word = windows[k].base;
			if (req.addr[CFG_AW-1:0] == CFG_AW'(2 * k + 2))
				rd_word = windows[k].size;
		end
	end

	// readback held for the data phase only
	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			config_reg_data <= '0;
		else
			config_reg_data <= (accept && cfg_hit && !req.write) ? rd_word : '0;
	end

endmodule

/* src/ahb_slave_decoder.sv */
`timescale 1ns/1ps
// combinational address decode into per-slave selects plus the valid strobe
module ahb_slave_decoder
	import ahb_cfg_pkg::*;
(
	input  ahb_req_t              req,
	input  window_array_t         windows,
	input  logic                  Hreadyin,
	input  hresp_e                Hresp,
	output logic [NUM_SLAVES-1:0] Pselx_out,
	output logic                  valid
);

	function automatic logic windows_disjoint(input window_array_t w);
		for (int i = 0; i < NUM_SLAVES; i++)
			for (int j = i + 1; j < NUM_SLAVES; j++)
				if (w[i].base < w[j].base + w[j].size && w[j].base < w[i].base + w[i].size)
					return 1'b0;
		return 1'b1;
	endfunction

	always_comb
	begin
		for (int k = 0; k < NUM_SLAVES; k++)
			Pselx_out[k] = (req.addr >= windows[k].base) &&
				(req.addr < windows[k].base + windows[k].size);   // upper bound exclusive
	end

	// config writes stay local, never forwarded
	assign valid = Hreadyin && is_active(req.trans) && (Hresp == OKAY) &&
		(!req.write || !is_cfg_addr(req.addr));

	a_onehot_select: assert final (!windows_disjoint(windows) || $onehot0(Pselx_out));

endmodule

/* src/ahb_protocol_checker.sv */
`timescale 1ns/1ps
// address phase rule checks, raises a one-cycle error_flag for the response FSM
module ahb_protocol_checker
	import ahb_cfg_pkg::*;
(
	input  logic     Hclk,
	input  logic     Hresetn,
	input  ahb_req_t req,
	input  logic     Hreadyin,
	input  logic     resp_busy,
	output logic     error_flag
);

	logic              accept;
	logic              misaligned;
	logic              seq_after_idle;
	logic              burst_change;
	logic              oversize;
	logic [DATA_W-1:0] size_mask;
	htrans_e           prev_trans;   // Htrans of the previous cycle
	logic [2:0]        last_size;
	logic              last_write;

	// phase taken while bus ready and no response running
	assign accept = Hreadyin && is_active(req.trans) && !resp_busy;

	assign size_mask  = (DATA_W'(1) << req.size) - DATA_W'(1);
	assign misaligned = !is_cfg_addr(req.addr) && ((req.addr & size_mask) != '0);

	assign seq_after_idle = (req.trans == SEQ) && (prev_trans == IDLE);
	assign burst_change   = (req.trans == SEQ) && (prev_trans == NONSEQ) &&
		((req.size != last_size) || (req.write != last_write));
	assign oversize = req.size > MAX_HSIZE;   // wider than the data bus

	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
		begin
			error_flag <= 1'b0;
			prev_trans <= IDLE;
			last_size  <= '0;
			last_write <= 1'b0;
		end
		else
		begin
			error_flag <= accept && (misaligned || seq_after_idle || burst_change || oversize);
			if (Hreadyin)
				prev_trans <= req.trans;
			if (accept)
			begin
				last_size  <= req.size;
				last_write <= req.write;
			end
		end
	end

	a_single_pulse: assert property (@(posedge Hclk) disable iff (!Hresetn)
		error_flag |=> !error_flag);

	// responder must pick up every flagged phase
	a_flag_to_busy: assert property (@(posedge Hclk) disable iff (!Hresetn)
		error_flag |=> resp_busy);

endmodule

/* src/ahb_error_responder.sv */
`timescale 1ns/1ps
// two-cycle AHB ERROR response FSM and the Hreadyout mux
module ahb_error_responder
	import ahb_cfg_pkg::*;
(
	input  logic   Hclk,
	input  logic   Hresetn,
	input  logic   error_flag,
	input  logic   cfg_write_phase,
	input  logic   Hreadyout_in,
	output hresp_e Hresp,
	output logic   Hreadyout,
	output logic   resp_busy
);

	resp_state_e state;

	// runs to the end regardless of Hreadyin
	always_ff @(posedge Hclk or negedge Hresetn)
	begin
		if (!Hresetn)
			state <= RESP_OK;
		else
		begin
			case (state)
				RESP_OK:
				begin
					if (error_flag)
						state <= RESP_ERR_FIRST;
				end
				RESP_ERR_FIRST: state <= RESP_ERR_LAST;
				default:        state <= RESP_OK;
			endcase
		end
	end

	assign resp_busy = (state != RESP_OK);
	assign Hresp     = resp_busy ? ERROR : OKAY;

	always_comb
	begin
		case (state)
			RESP_ERR_FIRST: Hreadyout = 1'b0;   // stall master
			RESP_ERR_LAST:  Hreadyout = 1'b1;
			default:        Hreadyout = cfg_write_phase ? 1'b1 : Hreadyout_in;
		endcase
	end

	// first error cycle on the bus is always followed by the last one
	a_err_two_cycle: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Hresp == ERROR && !Hreadyout) |=> (Hresp == ERROR && Hreadyout));

endmodule

/* src/ahb_config_bridge.sv */
`timescale 1ns/1ps
// top of the AHB config and decode bridge, packs the address phase and wires the four blocks
module ahb_config_bridge
	import ahb_cfg_pkg::*;
(
	input  logic                  Hclk,
	input  logic                  Hresetn,
	input  logic [1:0]            Htrans,
	input  logic [2:0]            Hsize,
	input  logic                  Hwrite,
	input  logic [DATA_W-1:0]     Haddr,
	input  logic [DATA_W-1:0]     Hwdata,
	input  logic                  Hreadyin,
	input  logic                  Hreadyout_in,
	output hresp_e                Hresp,
	output logic                  Hreadyout,
	output logic [NUM_SLAVES-1:0] Pselx_out,
	output logic                  valid,
	output logic [DATA_W-1:0]     config_reg_data
);

	ahb_req_t      req;
	window_array_t windows;
	logic          error_flag;
	logic          resp_busy;
	logic          cfg_write_phase;

	assign req = '{trans: htrans_e'(Htrans), size: Hsize, write: Hwrite, addr: Haddr};

	ahb_cfg_regs u_regs (
		.Hclk(Hclk), .Hresetn(Hresetn), .req(req), .Hreadyin(Hreadyin), .Hwdata(Hwdata),
		.error_flag(error_flag), .resp_busy(resp_busy), .windows(windows),
		.config_reg_data(config_reg_data), .cfg_write_phase(cfg_write_phase)
	);

	ahb_slave_decoder u_decoder (
		.req(req), .windows(windows), .Hreadyin(Hreadyin), .Hresp(Hresp),
		.Pselx_out(Pselx_out), .valid(valid)
	);

	ahb_protocol_checker u_checker (
		.Hclk(Hclk), .Hresetn(Hresetn), .req(req), .Hreadyin(Hreadyin),
		.resp_busy(resp_busy), .error_flag(error_flag)
	);

	ahb_error_responder u_responder (
		.Hclk(Hclk), .Hresetn(Hresetn), .error_flag(error_flag),
		.cfg_write_phase(cfg_write_phase), .Hreadyout_in(Hreadyout_in),
		.Hresp(Hresp), .Hreadyout(Hreadyout), .resp_busy(resp_busy)
	);

endmodule

/* verification/tb_ahb_config_bridge.sv */
`timescale 1ns/1ps
// self-checking testbench for the AHB config bridge; run as top with the sources from the file list
module tb_ahb_config_bridge
	import ahb_cfg_pkg::*;
();

	localparam int CYCLE_LIMIT = 600;   // all tests need well under 200 cycles

	logic                  Hclk;
	logic                  Hresetn;
	logic [1:0]            Htrans;
	logic [2:0]            Hsize;
	logic                  Hwrite;
	logic [DATA_W-1:0]     Haddr;
	logic [DATA_W-1:0]     Hwdata;
	logic                  Hreadyin;
	logic                  Hreadyout_in;
	hresp_e                Hresp;
	logic                  Hreadyout;
	logic [NUM_SLAVES-1:0] Pselx_out;
	logic                  valid;
	logic [DATA_W-1:0]     config_reg_data;

	window_array_t exp_win;   // expected window contents
	int            errors = 0;
	int            test_start = 0;
	int            tests_run = 0;
	int            tests_failed = 0;
	int            cycles = 0;

	ahb_config_bridge uut (.*);

	initial
	begin
		Hclk = 1'b0;
		forever #2 Hclk = ~Hclk;
	end

	always @(posedge Hclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run stopped after %0d cycles, DUT never finished the tests", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	a_no_valid_in_error: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Hresp == ERROR) |-> !valid)
	else
	begin
		$display("valid went high while an ERROR response was on the bus");
		errors++;
	end

	task automatic check_val(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		assert (got === exp)
		else
		begin
			$display("[FAIL] %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start)
			$display("test %-22s ok", name);
		else
		begin
			tests_failed++;
			$display("test %-22s failed", name);
		end
		test_start = errors;
	endtask

	task automatic address_phase(input htrans_e trans, input logic [2:0] size,
		input logic write, input logic [DATA_W-1:0] addr);
		@(posedge Hclk);
		Htrans <= trans;
		Hsize  <= size;
		Hwrite <= write;
		Haddr  <= addr;
	endtask

	task automatic cfg_read(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] exp);
		address_phase(NONSEQ, 3'd2, 1'b0, addr);
		@(posedge Hclk);
		Htrans <= IDLE;
		@(negedge Hclk);   // data phase
		check_val($sformatf("config_reg_data@%0h", addr), config_reg_data, exp);
	endtask

	task automatic cfg_write(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
		address_phase(NONSEQ, 3'd2, 1'b1, addr);
		Hreadyout_in <= 1'b0;   // must be overridden
		@(negedge Hclk);
		check_val("Hreadyout", Hreadyout, 1'b1);
		check_val("valid", valid, 1'b0);
		@(posedge Hclk);
		Htrans       <= IDLE;
		Hwdata       <= data;
		Hreadyout_in <= 1'b1;
		@(posedge Hclk);
	endtask

	task automatic check_decode(input logic [DATA_W-1:0] addr);
		logic [NUM_SLAVES-1:0] sel;
		for (int k = 0; k < NUM_SLAVES; k++)
			sel[k] = ({1'b0, addr} >= {1'b0, exp_win[k].base}) &&
				({1'b0, addr} < {1'b0, exp_win[k].base} + exp_win[k].size);
		@(posedge Hclk);
		Haddr <= addr;
		@(negedge Hclk);
		check_val($sformatf("Pselx_out@%h", addr), Pselx_out, sel);
	endtask

	task automatic random_decode(input int n);
		logic [DATA_W-1:0] addr;
		repeat (n)
		begin
			addr = exp_win[$urandom % NUM_SLAVES].base + ($urandom % 32'h800);
			check_decode(addr);
		end
	endtask

	// call right after the faulty phase went onto the bus
	task automatic expect_error();
		@(posedge Hclk);
		Htrans <= IDLE;
		@(negedge Hclk);
		check_val("Hresp", Hresp, OKAY);
		address_phase(NONSEQ, 3'd2, 1'b0, 32'h8000_0010);   // retry, must not reach a slave
		@(negedge Hclk);
		check_val("Hresp", Hresp, ERROR);
		check_val("Hreadyout", Hreadyout, 1'b0);
		check_val("valid", valid, 1'b0);
		@(negedge Hclk);
		check_val("Hresp", Hresp, ERROR);
		check_val("Hreadyout", Hreadyout, 1'b1);
		check_val("valid", valid, 1'b0);
		@(posedge Hclk);
		Htrans <= IDLE;
		@(negedge Hclk);
		check_val("Hresp", Hresp, OKAY);
	endtask

	initial
	begin
		void'($urandom(32'hcea6));
		Hresetn      = 1'b0;
		Htrans       = IDLE;
		Hsize        = 3'd2;
		Hwrite       = 1'b0;
		Haddr        = '0;
		Hwdata       = '0;
		Hreadyin     = 1'b1;
		Hreadyout_in = 1'b1;
		for (int k = 0; k < NUM_SLAVES; k++)
		begin
			exp_win[k].base = 32'h8000_0000 + k * 32'h0400_0000;
			exp_win[k].size = 32'h3ff;
		end
		repeat (8) @(posedge Hclk);
		Hresetn <= 1'b1;

		cfg_read(0, 0);
		for (int a = 1; a <= 8; a++)
			cfg_read(a, a[0] ? exp_win[(a - 1) / 2].base : exp_win[(a - 1) / 2].size);
		random_decode(12);
		end_test("reset defaults");

		cfg_write(3, 32'h9000_0000);
		cfg_write(4, 32'h1000);
		exp_win[1].base = 32'h9000_0000;
		exp_win[1].size = 32'h1000;
		cfg_read(3, 32'h9000_0000);
		cfg_read(4, 32'h1000);
		check_decode(32'h9000_0fff);
		check_decode(32'h9000_1000);   // one past the top
		random_decode(12);
		end_test("config write");

		address_phase(NONSEQ, 3'd1, 1'b0, 32'h8000_0001);
		expect_error();
		address_phase(NONSEQ, 3'd2, 1'b1, 32'h8800_0002);
		expect_error();
		address_phase(NONSEQ, 3'd2, 1'b0, 32'h8000_0004);
		expect_error_free: begin
			@(posedge Hclk);
			Htrans <= IDLE;
			repeat (3)
			begin
				@(negedge Hclk);
				check_val("Hresp", Hresp, OKAY);
			end
		end
		end_test("misalignment");

		address_phase(SEQ, 3'd2, 1'b0, 32'h8000_0000);
		expect_error();
		address_phase(NONSEQ, 3'd2, 1'b0, 32'h8000_0100);
		address_phase(SEQ, 3'd1, 1'b0, 32'h8000_0104);
		expect_error();
		address_phase(NONSEQ, 3'd2, 1'b0, 32'h8000_0200);
		address_phase(SEQ, 3'd2, 1'b1, 32'h8000_0204);
		expect_error();
		address_phase(NONSEQ, 3'd3, 1'b0, 32'h8800_0000);
		expect_error();
		end_test("burst rules");

		address_phase(NONSEQ, 3'd3, 1'b1, 5);   // oversize config write
		Hwdata <= 32'hdead_beef;
		expect_error();
		cfg_read(5, exp_win[2].base);
		address_phase(NONSEQ, 3'd2, 1'b0, 32'h8000_0020);
		Hreadyout_in <= 1'b0;
		@(negedge Hclk);
		check_val("Hreadyout", Hreadyout, 1'b0);
		check_val("valid", valid, 1'b1);
		@(posedge Hclk);
		Hreadyout_in <= 1'b1;
		@(negedge Hclk);
		check_val("Hreadyout", Hreadyout, 1'b1);
		@(posedge Hclk);
		Htrans <= IDLE;
		end_test("error side effects");

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* ahb_config_bridge.f */
src/ahb_cfg_pkg.sv
src/ahb_cfg_regs.sv
src/ahb_slave_decoder.sv
src/ahb_protocol_checker.sv
src/ahb_error_responder.sv
src/ahb_config_bridge.sv
verification/tb_ahb_config_bridge.sv

/* Bender.yml */
package:
  name: ahb_config_bridge

sources:
  - src/ahb_cfg_pkg.sv
  - src/ahb_cfg_regs.sv
  - src/ahb_slave_decoder.sv
  - src/ahb_protocol_checker.sv
  - src/ahb_error_responder.sv
  - src/ahb_config_bridge.sv
  - target: test
    files:
      - verification/tb_ahb_config_bridge.sv
